//--- callPanel.sv
`timescale 1ns/1ps
`include "lift_defines.svh"

module callPanel (
    input  logic                    clk,
    input  logic                    clear,
    input  logic                    callValid,
    input  liftTypesPkg::queueWordT call,
    output logic                    panelReq,
    output liftBusPkg::queueBusT    panelBus,
    input  logic                    panelGrant
);
    import liftTypesPkg::*;
    import liftBusPkg::*;

    localparam int PTR_W = $clog2(`PANEL_BUF_DEPTH);

    queueWordT fifoMem [`PANEL_BUF_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0] count;

    assign panelReq = count != '0;

    // priority calls jump to the front of the queue
    always_comb begin
        panelBus.word = fifoMem[rdPtr];
        panelBus.op = (fifoMem[rdPtr].fields.objType == objPriority) ? opFront : opAppend;
    end

    always_ff @(posedge clk) begin
        if (callValid) begin
            fifoMem[wrPtr] <= call;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (callValid) wrPtr <= wrPtr + 1'b1;
            if (panelGrant) rdPtr <= rdPtr + 1'b1; // grant only comes with a request
            case ({callValid, panelGrant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // credits upstream keep the buffer from filling past its depth
    noOverflow: assert property (
        @(posedge clk) disable iff (clear)
        callValid |-> (count < (PTR_W+1)'(`PANEL_BUF_DEPTH)) || panelGrant
    ) else $error("panel buffer overflow");

endmodule

//--- carSequencer.sv
`timescale 1ns/1ps
`include "lift_defines.svh"

module carSequencer (
    input  logic                    clk,
    input  logic                    clear,
    input  liftTypesPkg::queueWordT headWord,
    output logic                    seqReq,
    output liftBusPkg::queueBusT    seqBus,
    input  logic                    seqGrant,
    output logic                    creditReturn,
    output liftTypesPkg::floorT     carFloor,
    output logic                    doorOpen,
    output logic                    servedValid,
    output liftTypesPkg::queueWordT servedWord
);
    import liftTypesPkg::*;
    import liftBusPkg::*;

    localparam int TICK_W = $clog2(`FLOOR_TICKS + `DOOR_TICKS);

    typedef enum logic [2:0] {
        idle, moveToOrigin, doorAtOrigin, moveToDest, doorAtDest, done
    } stateT;

    stateT state;
    queueWordT curReq;
    logic [TICK_W-1:0] tickCnt;
    floorT target;
    floorT stepFloor;
    logic floorTick;
    logic doorTick;

    // skip the move when the car already stands at the target
    function automatic stateT enterMove(floorT fromFloor, floorT toFloor,
                                        stateT moveSt, stateT doorSt);
        return (fromFloor == toFloor) ? doorSt : moveSt;
    endfunction

    assign seqReq = (state == idle) && (headWord.raw != '0);
    assign seqBus.op = opPop;
    assign seqBus.word = '0;

    assign target = (state == moveToOrigin) ? curReq.fields.originFloor : curReq.fields.destFloor;
    assign stepFloor = (target > carFloor) ? carFloor + 2'd1 : carFloor - 2'd1;
    assign floorTick = tickCnt == TICK_W'(`FLOOR_TICKS - 1);
    assign doorTick = tickCnt == TICK_W'(`DOOR_TICKS - 1);

    assign doorOpen = (state == doorAtOrigin) || (state == doorAtDest);
    assign servedValid = state == done; // one cycle after the last door closes
    assign servedWord = curReq;

    always_ff @(posedge clk) begin
        if (state == idle && seqGrant) begin
            curReq <= headWord;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state <= idle;
            carFloor <= '0;
            tickCnt <= '0;
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= 1'b0;
            case (state)
                idle: begin
                    if (seqGrant) begin
                        creditReturn <= 1'b1; // slot freed by this pop
                        tickCnt <= '0;
                        if (headWord.fields.isHallCall) begin
                            state <= enterMove(carFloor, headWord.fields.originFloor,
                                               moveToOrigin, doorAtOrigin);
                        end else begin
                            state <= enterMove(carFloor, headWord.fields.destFloor,
                                               moveToDest, doorAtDest);
                        end
                    end
                end
                moveToOrigin, moveToDest: begin
                    if (floorTick) begin
                        tickCnt <= '0;
                        carFloor <= stepFloor;
                        if (stepFloor == target) begin
                            state <= (state == moveToOrigin) ? doorAtOrigin : doorAtDest;
                        end
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                doorAtOrigin: begin
                    if (doorTick) begin
                        tickCnt <= '0;
                        state <= enterMove(carFloor, curReq.fields.destFloor,
                                           moveToDest, doorAtDest);
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                doorAtDest: begin
                    if (doorTick) begin
                        tickCnt <= '0;
                        state <= done;
                    end else begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // the served request always ends at its destination
    servedAtDest: assert property (
        @(posedge clk) disable iff (clear)
        servedValid |-> carFloor == servedWord.fields.destFloor
    ) else $error("request served away from its destination");

endmodule

//--- liftBusPkg.sv
package liftBusPkg;

    // operations on the queue's single write port
    typedef enum logic [1:0] {
        opNone   = 2'd0,
        opAppend = 2'd1, // first empty slot
        opFront  = 2'd2, // insert at slot 0, rest moves back
        opPop    = 2'd3  // drop slot 0, rest moves forward
    } queueOpT;

    typedef struct packed {
        queueOpT                 op;
        liftTypesPkg::queueWordT word; // ignored on pop
    } queueBusT;

endpackage

//--- liftTop.sv
`timescale 1ns/1ps
`include "lift_defines.svh"

module liftTop (
    input  logic                     clk,
    input  logic                     clear,
    input  logic                     callValid,
    input  liftTypesPkg::queueWordT  call,
    output logic                     creditReturn,
    input  logic [`QUEUE_ADDR_W-1:0] monitorAddr,
    output liftTypesPkg::queueWordT  monitorWord,
    output liftTypesPkg::floorT      carFloor,
    output logic                     doorOpen,
    output logic                     servedValid,
    output liftTypesPkg::queueWordT  servedWord
);
    import liftTypesPkg::*;
    import liftBusPkg::*;

    logic panelReq;
    logic panelGrant;
    logic seqReq;
    logic seqGrant;
    queueBusT panelBus;
    queueBusT seqBus;
    queueBusT queueBus; // granted operation
    queueWordT headWord;

    callPanel panel (
        .clk(clk), .clear(clear), .callValid(callValid), .call(call),
        .panelReq(panelReq), .panelBus(panelBus), .panelGrant(panelGrant)
    );

    carSequencer sequencer (
        .clk(clk), .clear(clear), .headWord(headWord),
        .seqReq(seqReq), .seqBus(seqBus), .seqGrant(seqGrant),
        .creditReturn(creditReturn), .carFloor(carFloor), .doorOpen(doorOpen),
        .servedValid(servedValid), .servedWord(servedWord)
    );

    queueArbiter arbiter (
        .clk(clk), .clear(clear),
        .panelReq(panelReq), .panelBus(panelBus), .panelGrant(panelGrant),
        .seqReq(seqReq), .seqBus(seqBus), .seqGrant(seqGrant),
        .queueBus(queueBus)
    );

    requestQueue queue (
        .clk(clk), .clear(clear), .queueBus(queueBus), .monitorAddr(monitorAddr),
        .headWord(headWord), .monitorWord(monitorWord)
    );

endmodule

//--- liftTypesPkg.sv
package liftTypesPkg;

    typedef logic [1:0] floorT; // floors 0 to 3

    // none is reserved, so a valid request word is never all zero
    typedef enum logic [1:0] {
        objNone      = 2'd0,
        objPassenger = 2'd1,
        objCargo     = 2'd2,
        objPriority  = 2'd3
    } objectT;

    // same bit layout as the old ram word
    typedef struct packed {
        logic   isHallCall;  // 1: stop at origin first
        objectT objType;
        floorT  originFloor;
        floorT  destFloor;
    } requestFieldsT;

    // the sequencer reads fields, the queue tests raw for an empty slot
    typedef union packed {
        requestFieldsT fields;
        logic [6:0]    raw;
    } queueWordT;

endpackage

//--- lift_defines.svh
`ifndef LIFT_DEFINES_SVH
`define LIFT_DEFINES_SVH

// queue slots, also the number of source credits
`define QUEUE_DEPTH 16
`define QUEUE_ADDR_W 4

`define PANEL_BUF_DEPTH 4 // calls held in the panel before they reach the queue

// car timing in clock cycles
`define FLOOR_TICKS 4 // travel time per floor
`define DOOR_TICKS 3  // door open time per stop

`endif

//--- list.f
+incdir+.
liftTypesPkg.sv
liftBusPkg.sv
requestQueue.sv
queueArbiter.sv
callPanel.sv
carSequencer.sv
liftTop.sv
tbLift.sv

//--- queueArbiter.sv
`timescale 1ns/1ps

module queueArbiter (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 panelReq,
    input  liftBusPkg::queueBusT panelBus,
    output logic                 panelGrant,
    input  logic                 seqReq,
    input  liftBusPkg::queueBusT seqBus,
    output logic                 seqGrant,
    output liftBusPkg::queueBusT queueBus
);
    import liftBusPkg::*;

    logic lastWasSeq; // sequencer was served last

    // on a tie the peer not served last wins
    assign panelGrant = panelReq && (!seqReq || lastWasSeq);
    assign seqGrant = seqReq && (!panelReq || !lastWasSeq);

    always_comb begin
        queueBus = '0;
        queueBus.op = opNone;
        if (panelGrant) begin
            queueBus = panelBus;
        end else if (seqGrant) begin
            queueBus = seqBus;
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            lastWasSeq <= 1'b0;
        end else if (panelGrant) begin
            lastWasSeq <= 1'b0;
        end else if (seqGrant) begin
            lastWasSeq <= 1'b1;
        end
    end

    oneGrant: assert property (
        @(posedge clk) disable iff (clear)
        !(panelGrant && seqGrant)
    ) else $error("both peers granted");

endmodule

//--- requestQueue.sv
`timescale 1ns/1ps
`include "lift_defines.svh"

module requestQueue (
    input  logic                     clk,
    input  logic                     clear,
    input  liftBusPkg::queueBusT     queueBus,
    input  logic [`QUEUE_ADDR_W-1:0] monitorAddr,
    output liftTypesPkg::queueWordT  headWord,
    output liftTypesPkg::queueWordT  monitorWord
);
    import liftTypesPkg::*;
    import liftBusPkg::*;

    queueWordT slots [`QUEUE_DEPTH];
    logic [`QUEUE_ADDR_W-1:0] monitorAddrQ;
    logic [`QUEUE_ADDR_W-1:0] freeIdx;
    logic found;

    // lowest empty slot for append
    always_comb begin
        freeIdx = '0;
        found = 1'b0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            if (!found && slots[i].raw == '0) begin
                freeIdx = `QUEUE_ADDR_W'(i);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            for (int i = 0; i < `QUEUE_DEPTH; i++) begin
                slots[i] <= '0;
            end
            monitorAddrQ <= '0;
        end else begin
            case (queueBus.op)
                opAppend: begin
                    if (found) begin
                        slots[freeIdx] <= queueBus.word;
                    end
                end
                opFront: begin
                    // everything moves back one, the tail word falls off
                    for (int i = 1; i < `QUEUE_DEPTH; i++) begin
                        slots[i] <= slots[i-1];
                    end
                    slots[0] <= queueBus.word;
                end
                opPop: begin
                    for (int i = 0; i < `QUEUE_DEPTH - 1; i++) begin
                        slots[i] <= slots[i+1];
                    end
                    slots[`QUEUE_DEPTH-1] <= '0; // tail becomes free
                end
                default: ;
            endcase
            monitorAddrQ <= monitorAddr;
        end
    end

    assign headWord = slots[0];
    assign monitorWord = slots[monitorAddrQ]; // address seen one cycle earlier

    // source credits must keep the tail free whenever a word is written
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (clear)
        (queueBus.op == opAppend || queueBus.op == opFront)
            |-> slots[`QUEUE_DEPTH-1].raw == '0
    ) else $error("queue write with slot %0d occupied", `QUEUE_DEPTH - 1);

    // the sequencer only asks for a pop when it saw a request at the head
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (clear)
        queueBus.op == opPop |-> headWord.raw != '0
    ) else $error("pop of an empty queue head");

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the lift testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timing -f list.f --top-module tbLift -o simLift
./obj_dir/simLift 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0

//--- tbLift.sv
`timescale 1ns/1ps
`include "lift_defines.svh"

module tbLift;
    import liftTypesPkg::*;

    // worst service: two trips over 3 floors, two door stops, plus handshake slack
    localparam int SERVICE_MAX = 2 * 3 * `FLOOR_TICKS + 2 * `DOOR_TICKS + 4;
    localparam int CYCLE_LIMIT = 2 * 40 * SERVICE_MAX;

    logic clk = 1'b0;
    logic clear = 1'b1;
    logic callValid = 1'b0;
    queueWordT call = '0;
    logic [`QUEUE_ADDR_W-1:0] monitorAddr = '0;
    logic creditReturn;
    queueWordT monitorWord;
    floorT carFloor;
    logic doorOpen;
    logic servedValid;
    queueWordT servedWord;

    queueWordT modelQ[$]; // expected queue contents, head first
    queueWordT expServed = '0;
    logic [31:0] lfsr = 32'h9ebd;
    int credits = `QUEUE_DEPTH;
    int sentCount = 0;
    int popCount = 0;
    int servedCount = 0;
    int failCount = 0;
    int motionFails = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycles = 0;
    bit popSeen;

    liftTop UUT (
        .clk(clk), .clear(clear), .callValid(callValid), .call(call),
        .creditReturn(creditReturn), .monitorAddr(monitorAddr), .monitorWord(monitorWord),
        .carFloor(carFloor), .doorOpen(doorOpen), .servedValid(servedValid),
        .servedWord(servedWord)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the car stopped serving requests", cycles);
            $display("Test failed");
            $finish;
        end
    end

    orderCheck: assert property (@(posedge clk) disable iff (clear)
        servedValid |-> servedWord == expServed)
    else begin
        $display("[FAIL] order: expected %h actual %h", expServed, servedWord);
        failCount++;
    end

    stepCheck: assert property (@(posedge clk) disable iff (clear)
        carFloor != $past(carFloor) |-> (int'(carFloor) == int'($past(carFloor)) + 1)
            || (int'(carFloor) + 1 == int'($past(carFloor))))
    else begin
        $display("car jumped more than one floor");
        failCount++;
        motionFails++;
    end

    doorCheck: assert property (@(posedge clk) disable iff (clear)
        doorOpen && $past(doorOpen) |-> $stable(carFloor))
    else begin
        $display("car moved while the door was open");
        failCount++;
        motionFails++;
    end

    destCheck: assert property (@(posedge clk) disable iff (clear)
        servedValid |-> carFloor == expServed.fields.destFloor)
    else begin
        $display("[FAIL] car motion: expected floor %0d actual %0d",
                 expServed.fields.destFloor, carFloor);
        failCount++;
        motionFails++;
    end

    function automatic logic takeBit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic queueWordT randomWord(bit urgent);
        queueWordT w;
        w.fields.isHallCall = takeBit();
        w.fields.objType = takeBit() ? objCargo : objPassenger;
        if (urgent) w.fields.objType = objPriority;
        w.fields.originFloor = {takeBit(), takeBit()};
        w.fields.destFloor = {takeBit(), takeBit()};
        return w;
    endfunction

    // every wait goes through here so the model tracks pops in step
    task automatic stepCycle();
        @(negedge clk);
        if (creditReturn) begin
            expServed = modelQ.pop_front();
            credits++;
            popCount++;
            popSeen = 1'b1;
        end
        if (servedValid) servedCount++;
    endtask

    task automatic sendCall(queueWordT w);
        while (credits == 0) stepCycle();
        callValid = 1'b1;
        call = w;
        credits--;
        sentCount++;
        if (w.fields.objType == objPriority) modelQ.push_front(w);
        else modelQ.push_back(w);
        stepCycle();
        callValid = 1'b0;
        repeat (2) stepCycle(); // one call in flight at a time
    endtask

    task automatic readBack(string name);
        queueWordT exp;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            monitorAddr = i[`QUEUE_ADDR_W-1:0];
            stepCycle();
            exp = (i < modelQ.size()) ? modelQ[i] : '0;
            slotCheck: assert (monitorWord == exp) else begin
                $display("[FAIL] %s slot %0d: expected %h actual %h", name, i, exp, monitorWord);
                failCount++;
            end
        end
    endtask

    task automatic reportTest(string name, int failsBefore);
        if (failCount == failsBefore) begin
            $display("test %s: ok", name);
            testsPassed++;
        end else begin
            $display("test %s: %0d errors", name, failCount - failsBefore);
            testsFailed++;
        end
    endtask

    initial begin
        int fails;
        repeat (2) @(posedge clk);
        @(negedge clk);
        clear = 1'b0;

        fails = failCount;
        resetCheck: assert (!doorOpen && !servedValid && !creditReturn && carFloor == 0)
        else begin
            $display("outputs not idle after reset");
            failCount++;
        end
        readBack("reset");
        reportTest("reset", fails);

        fails = failCount;
        for (int n = 0; n < 10; n++) sendCall(randomWord(1'b0));
        reportTest("order", fails);

        fails = failCount;
        for (int n = 0; n < 3; n++) sendCall(randomWord(1'b0));
        popSeen = 1'b0;
        while (!popSeen) stepCycle(); // car just started a request, so it is busy
        sendCall(randomWord(1'b1));
        readBack("priority");
        reportTest("priority", fails);

        fails = failCount;
        while (credits > 0) sendCall(randomWord(1'b0));
        repeat (3) stepCycle();
        readBack("fill");
        while (servedCount < sentCount) stepCycle();
        creditCheck: assert (popCount == sentCount && servedCount == sentCount) else begin
            $display("[FAIL] credits: expected %0d pops and serves, actual %0d pops %0d serves",
                     sentCount, popCount, servedCount);
            failCount++;
        end
        reportTest("credits", fails);
        reportTest("car motion", failCount - motionFails); // motion assertions span the run

        $display("tests passed %0d, tests failed %0d, checks failed %0d",
                 testsPassed, testsFailed, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
